// ==== Bender.yml ====
package:
  name: conv3x3

sources:
  - files:
      - logic/conv_pkg.sv
      - logic/row_fifo.sv
      - logic/line_3_buffer.sv
      - logic/conv3x3_engine.sv
      - logic/conv_ctrl.sv
      - logic/conv_top.sv
  - target: simulation
    files:
      - sim/conv_chk.sv
      - sim/conv_tb.sv

// ==== filelist.f ====
logic/conv_pkg.sv
logic/row_fifo.sv
logic/line_3_buffer.sv
logic/conv3x3_engine.sv
logic/conv_ctrl.sv
logic/conv_top.sv
sim/conv_chk.sv
sim/conv_tb.sv

// ==== logic/conv3x3_engine.sv ====
`timescale 1ns/1ps

module conv3x3_engine (
    input  logic               clk,
    input  logic               resetn,
    input  conv_pkg::wgt_set_t weights_i,
    input  conv_pkg::window_t  win_i,
    input  logic               win_valid_i,
    output logic               win_ready_o,
    output conv_pkg::res_row_t res_o,
    output logic               res_valid_o,
    input  logic               res_ready_i
);
    conv_pkg::pad_row_t rows [3];
    logic signed [conv_pkg::PROD_BITS-1:0] prod_q [conv_pkg::IMG_W][conv_pkg::N_WGT];
    logic signed [conv_pkg::ACC_BITS-1:0] sum_d [conv_pkg::IMG_W];
    conv_pkg::res_row_t res_q;
    logic v1_q;
    logic v2_q;
    logic en;

    assign rows[0] = win_i.top;
    assign rows[1] = win_i.mid;
    assign rows[2] = win_i.bot;

    // Whole pipeline holds only when the output is refused
    assign en          = ~(v2_q & ~res_ready_i);
    assign win_ready_o = en;
    assign res_o       = res_q;
    assign res_valid_o = v2_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else if (en) begin
            v1_q <= win_valid_i;
            v2_q <= v1_q;
        end
    end

    // ------------------------------------------------------------
    // Stage 1: products
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (en) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                for (int k = 0; k < conv_pkg::N_WGT; k++) begin
                    // Pixels are unsigned
                    prod_q[c][k] <= $signed(weights_i.w[k])
                                    * $signed({1'b0, rows[k / 3].pix[c + k % 3]});
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Stage 2: column sums
    // ------------------------------------------------------------
    always_comb begin
        for (int c = 0; c < conv_pkg::IMG_W; c++) begin
            sum_d[c] = '0;
            for (int k = 0; k < conv_pkg::N_WGT; k++) begin
                sum_d[c] = sum_d[c] + conv_pkg::ACC_BITS'(prod_q[c][k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                res_q.sum[c] <= sum_d[c];
            end
        end
    end

endmodule

// ==== logic/conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl (
    input  logic                clk,
    input  logic                resetn,
    input  conv_pkg::axil_req_t axil_req_i,
    output conv_pkg::axil_rsp_t axil_rsp_o,
    output conv_pkg::wgt_set_t  weights_o,
    output logic                row_accept_o,
    input  logic                row_taken_i,
    input  logic                res_done_i,
    output logic                lb_clear_o,
    output logic                lb_flush_o
);
    logic aw_ready_q;
    logic w_ready_q;
    logic aw_held_q;
    logic w_held_q;
    logic b_valid_q;
    logic ar_ready_q;
    logic r_valid_q;
    logic [conv_pkg::AXI_ADDR_BITS-1:0] aw_addr_q;
    logic [conv_pkg::AXI_DATA_BITS-1:0] w_data_q;
    logic [3:0] w_strb_q;
    logic [conv_pkg::AXI_DATA_BITS-1:0] r_data_q;
    logic [conv_pkg::AXI_DATA_BITS-1:0] rd_data;
    logic [conv_pkg::H_BITS-1:0] height_q;
    logic [conv_pkg::H_BITS-1:0] rows_in_q;
    logic [conv_pkg::H_BITS-1:0] rows_out_q;
    logic busy_q;
    logic done_q;
    logic flush_sent_q;
    logic wr_en;
    logic start;
    conv_pkg::wgt_set_t weights_q;

    assign wr_en        = aw_held_q & w_held_q;
    assign start        = wr_en & (aw_addr_q == conv_pkg::REG_CTRL) & w_strb_q[0]
                          & w_data_q[0] & ~busy_q;
    assign lb_clear_o   = start;
    assign row_accept_o = busy_q & (rows_in_q < height_q);
    assign weights_o    = weights_q;

    assign axil_rsp_o.aw_ready = aw_ready_q;
    assign axil_rsp_o.w_ready  = w_ready_q;
    assign axil_rsp_o.b_resp   = conv_pkg::RESP_OKAY;
    assign axil_rsp_o.b_valid  = b_valid_q;
    assign axil_rsp_o.ar_ready = ar_ready_q;
    assign axil_rsp_o.r_data   = r_data_q;
    assign axil_rsp_o.r_resp   = conv_pkg::RESP_OKAY;
    assign axil_rsp_o.r_valid  = r_valid_q;

    // ------------------------------------------------------------
    // AXI4-Lite handshakes
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            aw_ready_q <= 1'b0;
            w_ready_q  <= 1'b0;
            aw_held_q  <= 1'b0;
            w_held_q   <= 1'b0;
            b_valid_q  <= 1'b0;
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else begin
            aw_ready_q <= axil_req_i.aw_valid & ~aw_ready_q & ~aw_held_q & ~b_valid_q;
            w_ready_q  <= axil_req_i.w_valid & ~w_ready_q & ~w_held_q & ~b_valid_q;
            if (axil_req_i.aw_valid && aw_ready_q) begin
                aw_held_q <= 1'b1;
            end
            if (axil_req_i.w_valid && w_ready_q) begin
                w_held_q <= 1'b1;
            end
            // Both halves present, commit and respond
            if (wr_en) begin
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
                b_valid_q <= 1'b1;
            end else if (b_valid_q && axil_req_i.b_ready) begin
                b_valid_q <= 1'b0;
            end
            ar_ready_q <= axil_req_i.ar_valid & ~ar_ready_q & ~r_valid_q;
            if (axil_req_i.ar_valid && ar_ready_q) begin
                r_valid_q <= 1'b1;
            end else if (r_valid_q && axil_req_i.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (axil_req_i.aw_valid && aw_ready_q) begin
            aw_addr_q <= axil_req_i.aw_addr;
        end
        if (axil_req_i.w_valid && w_ready_q) begin
            w_data_q <= axil_req_i.w_data;
            w_strb_q <= axil_req_i.w_strb;
        end
        if (axil_req_i.ar_valid && ar_ready_q) begin
            r_data_q <= rd_data;
        end
    end

    always_comb begin
        rd_data = '0;
        case (axil_req_i.ar_addr)
            conv_pkg::REG_STATUS:   rd_data = {30'b0, done_q, busy_q};
            conv_pkg::REG_HEIGHT:   rd_data = 32'(height_q);
            conv_pkg::REG_ROWS_OUT: rd_data = 32'(rows_out_q);
            default:                rd_data = '0;
        endcase
        for (int i = 0; i < conv_pkg::N_WGT; i++) begin
            if (axil_req_i.ar_addr == conv_pkg::REG_WGT0 + 8'(4 * i)) begin
                rd_data = {{24{weights_q.w[i][7]}}, weights_q.w[i]};
            end
        end
    end

    // ------------------------------------------------------------
    // Registers and image sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            height_q     <= conv_pkg::H_BITS'(2);
            weights_q    <= '0;
            busy_q       <= 1'b0;
            done_q       <= 1'b0;
            rows_in_q    <= '0;
            rows_out_q   <= '0;
            flush_sent_q <= 1'b0;
            lb_flush_o   <= 1'b0;
        end else begin
            lb_flush_o <= 1'b0;
            if (wr_en && aw_addr_q == conv_pkg::REG_HEIGHT && w_strb_q[0] && !busy_q
                && w_data_q >= 2 && w_data_q <= conv_pkg::MAX_H) begin
                height_q <= w_data_q[conv_pkg::H_BITS-1:0];
            end
            for (int i = 0; i < conv_pkg::N_WGT; i++) begin
                if (wr_en && w_strb_q[0] && aw_addr_q == conv_pkg::REG_WGT0 + 8'(4 * i)) begin
                    weights_q.w[i] <= w_data_q[conv_pkg::WGT_BITS-1:0];
                end
            end
            if (start) begin
                busy_q       <= 1'b1;
                done_q       <= 1'b0;
                rows_in_q    <= '0;
                rows_out_q   <= '0;
                flush_sent_q <= 1'b0;
            end else if (busy_q) begin
                if (row_taken_i) begin
                    rows_in_q <= rows_in_q + 1'b1;
                end
                // One flush once every row has entered
                if (!flush_sent_q && rows_in_q == height_q) begin
                    flush_sent_q <= 1'b1;
                    lb_flush_o   <= 1'b1;
                end
                if (res_done_i) begin
                    rows_out_q <= rows_out_q + 1'b1;
                    if (rows_out_q == height_q - 1'b1) begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/conv_pkg.sv ====
package conv_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int PIX_BITS   = 8;
    localparam int IMG_W      = 8;
    localparam int MAX_H      = 31;
    localparam int H_BITS     = 5;
    localparam int WGT_BITS   = 8;
    localparam int N_WGT      = 9;
    localparam int PROD_BITS  = WGT_BITS + PIX_BITS + 1;
    localparam int ACC_BITS   = 20;
    localparam int FIFO_DEPTH = 4;

    localparam int AXI_ADDR_BITS = 8;
    localparam int AXI_DATA_BITS = 32;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam logic [AXI_ADDR_BITS-1:0] REG_CTRL     = 8'h00;
    localparam logic [AXI_ADDR_BITS-1:0] REG_STATUS   = 8'h04;
    localparam logic [AXI_ADDR_BITS-1:0] REG_HEIGHT   = 8'h08;
    localparam logic [AXI_ADDR_BITS-1:0] REG_ROWS_OUT = 8'h0C;
    localparam logic [AXI_ADDR_BITS-1:0] REG_WGT0     = 8'h10;

    // Pixel 0 sits in the low bits
    typedef struct packed {
        logic [IMG_W-1:0][PIX_BITS-1:0] pix;
    } pix_row_t;

    // Index 0 and IMG_W+1 are the zero pads
    typedef struct packed {
        logic [IMG_W+1:0][PIX_BITS-1:0] pix;
    } pad_row_t;

    typedef struct packed {
        pad_row_t top;
        pad_row_t mid;
        pad_row_t bot;
    } window_t;

    // Row-major, w[0] is top left
    typedef struct packed {
        logic [N_WGT-1:0][WGT_BITS-1:0] w;
    } wgt_set_t;

    typedef struct packed {
        logic [IMG_W-1:0][ACC_BITS-1:0] sum;
    } res_row_t;

    typedef struct packed {
        logic [AXI_ADDR_BITS-1:0] aw_addr;
        logic                     aw_valid;
        logic [AXI_DATA_BITS-1:0] w_data;
        logic [3:0]               w_strb;
        logic                     w_valid;
        logic                     b_ready;
        logic [AXI_ADDR_BITS-1:0] ar_addr;
        logic                     ar_valid;
        logic                     r_ready;
    } axil_req_t;

    typedef struct packed {
        logic                     aw_ready;
        logic                     w_ready;
        logic [1:0]               b_resp;
        logic                     b_valid;
        logic                     ar_ready;
        logic [AXI_DATA_BITS-1:0] r_data;
        logic [1:0]               r_resp;
        logic                     r_valid;
    } axil_rsp_t;

endpackage

// ==== logic/conv_top.sv ====
`timescale 1ns/1ps

module conv_top (
    input  logic                clk,
    input  logic                resetn,
    input  conv_pkg::axil_req_t axil_req_i,
    output conv_pkg::axil_rsp_t axil_rsp_o,
    input  conv_pkg::pix_row_t  row_i,
    input  logic                row_valid_i,
    output logic                row_ready_o,
    output conv_pkg::res_row_t  out_row_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);
    conv_pkg::wgt_set_t weights;
    conv_pkg::pix_row_t fifo_row;
    conv_pkg::window_t  win;
    conv_pkg::res_row_t res;
    logic row_accept;
    logic row_taken;
    logic in_wready;
    logic fifo_valid;
    logic fifo_ready;
    logic lb_clear;
    logic lb_flush;
    logic win_valid;
    logic win_ready;
    logic res_valid;
    logic res_ready;
    logic res_done;

    assign row_ready_o = row_accept & in_wready;
    assign row_taken   = row_valid_i & row_ready_o;
    assign res_done    = out_valid_o & out_ready_i;

    conv_ctrl u_ctrl (
        .clk, .resetn, .axil_req_i, .axil_rsp_o,
        .weights_o(weights), .row_accept_o(row_accept), .row_taken_i(row_taken),
        .res_done_i(res_done), .lb_clear_o(lb_clear), .lb_flush_o(lb_flush)
    );

    row_fifo #(.payload_t(conv_pkg::pix_row_t), .DEPTH(conv_pkg::FIFO_DEPTH)) u_in_fifo (
        .clk, .resetn, .clear_i(lb_clear),
        .wdata_i(row_i), .wvalid_i(row_valid_i & row_accept), .wready_o(in_wready),
        .rdata_o(fifo_row), .rvalid_o(fifo_valid), .rready_i(fifo_ready)
    );

    line_3_buffer u_lbuf (
        .clk, .resetn, .clear_i(lb_clear), .flush_i(lb_flush),
        .row_i(fifo_row), .row_valid_i(fifo_valid), .row_ready_o(fifo_ready),
        .win_o(win), .win_valid_o(win_valid), .win_ready_i(win_ready)
    );

    conv3x3_engine u_engine (
        .clk, .resetn, .weights_i(weights),
        .win_i(win), .win_valid_i(win_valid), .win_ready_o(win_ready),
        .res_o(res), .res_valid_o(res_valid), .res_ready_i(res_ready)
    );

    row_fifo #(.payload_t(conv_pkg::res_row_t), .DEPTH(conv_pkg::FIFO_DEPTH)) u_out_fifo (
        .clk, .resetn, .clear_i(lb_clear),
        .wdata_i(res), .wvalid_i(res_valid), .wready_o(res_ready),
        .rdata_o(out_row_o), .rvalid_o(out_valid_o), .rready_i(out_ready_i)
    );

endmodule

// ==== logic/line_3_buffer.sv ====
`timescale 1ns/1ps

module line_3_buffer (
    input  logic               clk,
    input  logic               resetn,
    input  logic               clear_i,
    input  logic               flush_i,
    input  conv_pkg::pix_row_t row_i,
    input  logic               row_valid_i,
    output logic               row_ready_o,
    output conv_pkg::window_t  win_o,
    output logic               win_valid_o,
    input  logic               win_ready_i
);
    conv_pkg::pad_row_t rows_q [3];
    logic [1:0] wr_ptr_q;
    logic [1:0] ptr_mid;
    logic [1:0] ptr_new;
    logic primed_q;
    logic flush_pend_q;
    logic win_valid_q;
    logic slot_free;
    logic take;
    logic flush_do;
    logic advance;

    // Write pointer always points at the oldest row
    assign ptr_mid = (wr_ptr_q == 2'd2) ? 2'd0 : wr_ptr_q + 2'd1;
    assign ptr_new = (ptr_mid == 2'd2) ? 2'd0 : ptr_mid + 2'd1;

    assign slot_free   = ~win_valid_q | win_ready_i;
    assign row_ready_o = slot_free;
    assign take        = row_valid_i & slot_free;
    // Flush waits until the last row has drained from the input side
    assign flush_do    = (flush_i | flush_pend_q) & ~row_valid_i & slot_free;
    assign advance     = take | flush_do;

    assign win_o.top   = rows_q[wr_ptr_q];
    assign win_o.mid   = rows_q[ptr_mid];
    assign win_o.bot   = rows_q[ptr_new];
    assign win_valid_o = win_valid_q;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr_q     <= 2'd0;
            primed_q     <= 1'b0;
            flush_pend_q <= 1'b0;
            win_valid_q  <= 1'b0;
        end else if (clear_i) begin
            wr_ptr_q     <= 2'd0;
            primed_q     <= 1'b0;
            flush_pend_q <= 1'b0;
            win_valid_q  <= 1'b0;
        end else begin
            if (advance) begin
                wr_ptr_q <= ptr_mid;
            end
            if (take) begin
                primed_q <= 1'b1;
            end
            // First row only fills the buffer
            if ((take && primed_q) || flush_do) begin
                win_valid_q <= 1'b1;
            end else if (win_ready_i) begin
                win_valid_q <= 1'b0;
            end
            if (flush_do) begin
                flush_pend_q <= 1'b0;
            end else if (flush_i) begin
                flush_pend_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Row storage
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (clear_i) begin
            for (int i = 0; i < 3; i++) begin
                rows_q[i] <= '0;
            end
        end else if (take) begin
            rows_q[wr_ptr_q] <= conv_pkg::pad_row_t'({{conv_pkg::PIX_BITS{1'b0}}, row_i,
                                                      {conv_pkg::PIX_BITS{1'b0}}});
        end else if (flush_do) begin
            // Bottom padding row
            rows_q[wr_ptr_q] <= '0;
        end
    end

endmodule

// ==== logic/row_fifo.sv ====
`timescale 1ns/1ps

module row_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     clear_i,
    input  payload_t wdata_i,
    input  logic     wvalid_i,
    output logic     wready_o,
    output payload_t rdata_o,
    output logic     rvalid_o,
    input  logic     rready_i
);
    payload_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic push;
    logic pop;

    assign wready_o = (count_q != DEPTH);
    assign rvalid_o = (count_q != 0);
    assign rdata_o  = mem[rd_ptr_q];
    assign push     = wvalid_i & wready_o;
    assign pop      = rvalid_o & rready_i;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

endmodule

// ==== sim/conv_chk.sv ====
`timescale 1ns/1ps

module conv_chk (
    input logic                clk,
    input logic                resetn,
    input conv_pkg::axil_req_t req_i,
    input conv_pkg::axil_rsp_t rsp_i,
    input logic                busy_i,
    input logic                row_ready_i,
    input conv_pkg::res_row_t  out_row_i,
    input logic                out_valid_i,
    input logic                out_ready_i
);
    // Result row holds while the sink stalls
    a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_row_i))
        else $error("result row dropped or changed while stalled");

    a_b_hold: assert property (@(posedge clk) disable iff (!resetn)
        rsp_i.b_valid && !req_i.b_ready |=> rsp_i.b_valid)
        else $error("bvalid dropped before bready");

    a_r_hold: assert property (@(posedge clk) disable iff (!resetn)
        rsp_i.r_valid && !req_i.r_ready |=> rsp_i.r_valid && $stable(rsp_i.r_data))
        else $error("rvalid or rdata changed before rready");

    // No rows accepted outside an image
    a_idle_ready: assert property (@(posedge clk) disable iff (!resetn)
        !busy_i |-> !row_ready_i)
        else $error("row_ready_o high while not busy");

endmodule

bind conv_top conv_chk u_chk (
    .clk, .resetn, .req_i(axil_req_i), .rsp_i(axil_rsp_o), .busy_i(u_ctrl.busy_q),
    .row_ready_i(row_ready_o), .out_row_i(out_row_o), .out_valid_i(out_valid_o),
    .out_ready_i(out_ready_i)
);

// ==== sim/conv_tb.sv ====
`timescale 1ns/1ps

module conv_tb;
    localparam int TOTAL_ROWS     = 6 + 5 + 5 + 2;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_ROWS + 2000;
    localparam int MAX_ROWS       = 8;

    logic                clk;
    logic                resetn;
    conv_pkg::axil_req_t axil_req;
    conv_pkg::axil_rsp_t axil_rsp;
    conv_pkg::pix_row_t  row;
    logic                row_valid;
    logic                row_ready;
    conv_pkg::res_row_t  out_row;
    logic                out_valid;
    logic                out_ready;

    int img [MAX_ROWS][conv_pkg::IMG_W];
    int wgt [conv_pkg::N_WGT];
    conv_pkg::res_row_t results [$];
    conv_pkg::res_row_t first_pass [$];
    int cycles;

    conv_top dut (
        .clk, .resetn, .axil_req_i(axil_req), .axil_rsp_o(axil_rsp),
        .row_i(row), .row_valid_i(row_valid), .row_ready_o(row_ready),
        .out_row_o(out_row), .out_valid_o(out_valid), .out_ready_i(out_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    // ------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s: got 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // AXI4-Lite master
    // ------------------------------------------------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        bit aw_hs;
        bit w_hs;
        @(negedge clk);
        axil_req.aw_addr  = addr;
        axil_req.aw_valid = 1'b1;
        axil_req.w_data   = data;
        axil_req.w_strb   = 4'hf;
        axil_req.w_valid  = 1'b1;
        while (axil_req.aw_valid || axil_req.w_valid) begin
            aw_hs = axil_req.aw_valid && axil_rsp.aw_ready;
            w_hs  = axil_req.w_valid && axil_rsp.w_ready;
            @(negedge clk);
            if (aw_hs) axil_req.aw_valid = 1'b0;
            if (w_hs) axil_req.w_valid = 1'b0;
        end
        while (!axil_rsp.b_valid) @(negedge clk);
        check_equal(axil_rsp.b_resp, conv_pkg::RESP_OKAY, "write response");
        // Response waits a cycle before bready
        @(negedge clk);
        axil_req.b_ready = 1'b1;
        @(negedge clk);
        axil_req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        bit ar_hs;
        @(negedge clk);
        axil_req.ar_addr  = addr;
        axil_req.ar_valid = 1'b1;
        while (axil_req.ar_valid) begin
            ar_hs = axil_rsp.ar_ready;
            @(negedge clk);
            if (ar_hs) axil_req.ar_valid = 1'b0;
        end
        while (!axil_rsp.r_valid) @(negedge clk);
        // Read data waits a cycle before rready
        @(negedge clk);
        data = axil_rsp.r_data;
        check_equal(axil_rsp.r_resp, conv_pkg::RESP_OKAY, "read response");
        axil_req.r_ready = 1'b1;
        @(negedge clk);
        axil_req.r_ready = 1'b0;
    endtask

    task automatic load_weights();
        for (int k = 0; k < conv_pkg::N_WGT; k++) begin
            axil_write(conv_pkg::REG_WGT0 + 8'(4 * k), 32'(wgt[k]));
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------
    task automatic fill_image(input int h);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                img[r][c] = int'($urandom_range(0, 255));
            end
        end
    endtask

    // Pixels outside the image count as zero
    function automatic int ref_sum(input int r, input int c, input int h);
        int s;
        int rr;
        int cc;
        s = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                rr = r + dy;
                cc = c + dx;
                if (rr >= 0 && rr < h && cc >= 0 && cc < conv_pkg::IMG_W) begin
                    s += wgt[(dy + 1) * 3 + dx + 1] * img[rr][cc];
                end
            end
        end
        return s;
    endfunction

    task automatic send_image(input int h, input int extra);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                row.pix[c] = 8'(img[r][c]);
            end
            row_valid = 1'b1;
            while (!row_ready) @(negedge clk);
            @(negedge clk);
        end
        // Rows beyond the height must be refused
        for (int i = 0; i < extra; i++) begin
            row = conv_pkg::pix_row_t'({$urandom, $urandom});
            row_valid = 1'b1;
            check_equal(row_ready, 1'b0, "row_ready_o with an extra row offered");
            @(negedge clk);
        end
        row_valid = 1'b0;
    endtask

    task automatic collect_results(input int h, input bit toggle);
        int got;
        got = 0;
        while (got < h) begin
            @(negedge clk);
            out_ready = toggle ? 1'($urandom_range(0, 1)) : 1'b1;
            if (out_valid && out_ready) begin
                results.push_back(out_row);
                got++;
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic run_image(input int h, input bit toggle, input int extra);
        logic [31:0] rd;
        results.delete();
        axil_write(conv_pkg::REG_CTRL, 32'h1);
        fork
            send_image(h, extra);
            collect_results(h, toggle);
        join
        repeat (4) @(negedge clk);
        check_equal(out_valid, 1'b0, "out_valid_o after the last row");
        axil_read(conv_pkg::REG_STATUS, rd);
        check_equal(rd, 32'h2, "status after image");
        axil_read(conv_pkg::REG_ROWS_OUT, rd);
        check_equal(rd, 32'(h), "rows out after image");
    endtask

    task automatic check_against_model(input int h);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                check_equal(results[r].sum[c],
                            $unsigned(conv_pkg::ACC_BITS'(ref_sum(r, c, h))),
                            $sformatf("sum at row %0d column %0d", r, c));
            end
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        void'($urandom(46));
        clk       = 1'b0;
        resetn    = 1'b0;
        axil_req  = '0;
        row       = '0;
        row_valid = 1'b0;
        out_ready = 1'b0;
        cycles    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // Idle state and register readback
        check_equal(out_valid, 1'b0, "out_valid_o after reset");
        check_equal(row_ready, 1'b0, "row_ready_o after reset");
        axil_read(conv_pkg::REG_STATUS, rd);
        check_equal(rd, 32'h0, "status after reset");
        axil_write(conv_pkg::REG_HEIGHT, 32'd6);
        axil_read(conv_pkg::REG_HEIGHT, rd);
        check_equal(rd, 32'd6, "height readback");
        for (int k = 0; k < conv_pkg::N_WGT; k++) begin
            wgt[k] = int'($urandom_range(0, 255)) - 128;
        end
        load_weights();
        for (int k = 0; k < conv_pkg::N_WGT; k++) begin
            axil_read(conv_pkg::REG_WGT0 + 8'(4 * k), rd);
            check_equal(rd, $unsigned(32'(wgt[k])), $sformatf("weight %0d readback", k));
        end

        // Identity kernel passes pixels through
        for (int k = 0; k < conv_pkg::N_WGT; k++) begin
            wgt[k] = (k == 4) ? 1 : 0;
        end
        load_weights();
        fill_image(6);
        run_image(6, 1'b0, 0);
        for (int r = 0; r < 6; r++) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                check_equal(results[r].sum[c], conv_pkg::ACC_BITS'(img[r][c]),
                            $sformatf("identity row %0d column %0d", r, c));
            end
        end

        // Random kernel, height 5
        for (int k = 0; k < conv_pkg::N_WGT; k++) begin
            wgt[k] = int'($urandom_range(0, 255)) - 128;
        end
        load_weights();
        axil_write(conv_pkg::REG_HEIGHT, 32'd5);
        fill_image(5);
        run_image(5, 1'b0, 0);
        check_against_model(5);
        first_pass = results;

        // Same image with a stalling sink and extra rows offered
        run_image(5, 1'b1, 4);
        check_against_model(5);
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                check_equal(results[r].sum[c], first_pass[r].sum[c],
                            $sformatf("repeat of row %0d column %0d", r, c));
            end
        end

        // Restart with two rows and new weights
        for (int k = 0; k < conv_pkg::N_WGT; k++) begin
            wgt[k] = int'($urandom_range(0, 255)) - 128;
        end
        load_weights();
        axil_write(conv_pkg::REG_HEIGHT, 32'd2);
        fill_image(2);
        run_image(2, 1'b0, 0);
        check_against_model(2);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
